/* vecmul_top.f */
src/vecmul_pkg.sv
src/modmul_lane.sv
src/vecmul_dispatch.sv
src/vecmul_collect.sv
src/vecmul_top.sv
tests/vecmul_assert.sv
tests/vecmul_tb.sv

/* Makefile */
# Verilator build and run of the vector modular multiplier testbench

VERILATOR ?= verilator
TOP       ?= vecmul_tb
FILELIST  ?= vecmul_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/vecmul_tb.sv */
// Testbench for the element-wise modular vector multiplier
// Xorshift stimulus, queue of expected products, checks and timeout

`timescale 1ns/100ps
`default_nettype none

module vecmul_tb;

  localparam int W = vecmul_pkg::WORD_W;
  // Elements per test, summed for the timeout
  localparam int N_SINGLE = 1;
  localparam int N_FULL   = 12;
  localparam int N_GAPPED = 9;
  localparam int N_EDGE   = 4;
  localparam int N_RESET  = 6 + 3 + 5;
  localparam int N_TOTAL  = N_SINGLE + N_FULL + N_GAPPED + 2 * N_EDGE + N_RESET;
  localparam int TIMEOUT_CYCLES = N_TOTAL * (W + 8) + 200;
  // Operand choice per run
  localparam int MODE_RANDOM = 0;
  localparam int MODE_GAPPED = 1;
  localparam int MODE_EDGE   = 2;

  logic               CLK;
  logic               RST;
  logic               start;
  vecmul_pkg::count_t size;
  vecmul_pkg::word_t  modulo;
  vecmul_pkg::word_t  data_a;
  vecmul_pkg::word_t  data_b;
  logic               data_in_valid;
  logic               data_in_ready;
  vecmul_pkg::word_t  data_out;
  logic               data_out_valid;
  logic               ready;

  // Reference model, products in input order
  vecmul_pkg::word_t expected [$];
  vecmul_pkg::word_t exp_word;
  logic [31:0]       rng = 32'h285cb821;
  string             test_name = "reset";
  int                error_count = 0;
  int                ready_count = 0;
  int                pass_count = 0;
  int                fail_count = 0;
  int                cycle_count = 0;

  vecmul_top #(
    .LANES(4)
  ) uut (
    .CLK(CLK), .RST(RST), .start(start), .size(size), .modulo(modulo),
    .data_a(data_a), .data_b(data_b), .data_in_valid(data_in_valid),
    .data_in_ready(data_in_ready), .data_out(data_out),
    .data_out_valid(data_out_valid), .ready(ready)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, run stuck in test %s", cycle_count, test_name);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Output checks against the model
  ////////////////////////////////////////

  // Mid-cycle sampling, outputs settled
  always @(negedge CLK) begin
    if (!RST && data_out_valid) begin
      assert (expected.size() > 0) else begin
        $display("Test %s: product %h came out with none expected", test_name, data_out);
        error_count++;
      end
      if (expected.size() > 0) begin
        exp_word = expected.pop_front();
        assert (data_out == exp_word) else begin
          $display("** Error %s: expected %h, actual %h", test_name, exp_word, data_out);
          error_count++;
        end
      end
    end
    if (!RST && ready) begin
      assert (expected.size() == 0) else begin
        $display("Test %s: ready with %0d products still due", test_name, expected.size());
        error_count++;
      end
      ready_count++;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic vecmul_pkg::word_t random_modulus();
    vecmul_pkg::word_t m;
    m = next_rand();
    return (m < 2) ? 32'd2 : m;
  endfunction

  // All tasks start and end 10 ns after a rising edge
  task automatic issue_start(input vecmul_pkg::word_t m, input int n);
    start  = 1'b1;
    size   = vecmul_pkg::count_t'(n);
    modulo = m;
    @(posedge CLK);
    #10;
    start = 1'b0;
  endtask

  task automatic send_pair(input vecmul_pkg::word_t a, input vecmul_pkg::word_t b,
                           input vecmul_pkg::word_t m, input bit gapped);
    logic [31:0] r;
    logic [63:0] prod;
    bit          sent;
    sent   = 1'b0;
    // Rule of the design, a*b mod m on full width
    prod   = (64'(a) * 64'(b)) % 64'(m);
    data_a = a;
    data_b = b;
    while (!sent) begin
      r = next_rand();
      data_in_valid = gapped ? (r[1:0] != 2'b00) : 1'b1;
      @(negedge CLK);
      // Transfer at the coming edge
      if (data_in_valid && data_in_ready) begin
        expected.push_back(prod[W-1:0]);
        sent = 1'b1;
      end
      @(posedge CLK);
      #10;
    end
  endtask

  task automatic send_vector(input vecmul_pkg::word_t m, input int n, input int mode);
    vecmul_pkg::word_t a;
    vecmul_pkg::word_t b;
    int                i;
    for (i = 0; i < n; i++) begin
      if (mode == MODE_EDGE) begin
        a = m - 1 - (next_rand() % 2);
        b = m - 1 - (next_rand() % 2);
      end else begin
        a = next_rand() % m;
        b = next_rand() % m;
      end
      send_pair(a, b, m, mode == MODE_GAPPED);
    end
    data_in_valid = 1'b0;
  endtask

  task automatic wait_ready(input int base);
    while (ready_count == base) begin
      @(posedge CLK);
      #10;
    end
  endtask

  task automatic report_test(input string name, input int base_err);
    if (error_count == base_err) begin
      pass_count++;
      $display("Test %s passed", name);
    end else begin
      fail_count++;
      $display("Test %s failed with %0d errors", name, error_count - base_err);
    end
  endtask

  task automatic run_vector(input string name, input vecmul_pkg::word_t m, input int n,
                            input int mode);
    int base_ready;
    int base_err;
    base_ready = ready_count;
    base_err   = error_count;
    test_name  = name;
    issue_start(m, n);
    send_vector(m, n, mode);
    wait_ready(base_ready);
    report_test(name, base_err);
  endtask

  ////////////////////////////////////////
  // Start during a run, reset mid-run
  ////////////////////////////////////////

  task automatic start_and_reset();
    vecmul_pkg::word_t m;
    int                base_ready;
    int                base_err;
    base_err   = error_count;
    test_name  = "start_and_reset";
    m          = random_modulus();
    base_ready = ready_count;
    issue_start(m, 6);
    send_vector(m, 2, MODE_RANDOM);
    // Second start with other size and modulus, must be ignored
    start  = 1'b1;
    size   = vecmul_pkg::count_t'(3);
    modulo = 32'd7;
    send_vector(m, 1, MODE_RANDOM);
    start  = 1'b0;
    send_vector(m, 3, MODE_RANDOM);
    wait_ready(base_ready);
    // Three elements in flight, then reset
    issue_start(m, 8);
    send_vector(m, 3, MODE_RANDOM);
    repeat (4) @(posedge CLK);
    #10 RST = 1'b1;
    expected.delete();
    repeat (3) @(posedge CLK);
    #10 RST = 1'b0;
    // Lanes would have finished here, no pulse may show up
    repeat (W + 20) @(posedge CLK);
    #10;
    m          = random_modulus();
    base_ready = ready_count;
    issue_start(m, 5);
    send_vector(m, 5, MODE_RANDOM);
    wait_ready(base_ready);
    report_test(test_name, base_err);
  endtask

  initial begin
    RST           = 1'b0;
    start         = 1'b0;
    size          = '0;
    modulo        = '0;
    data_a        = '0;
    data_b        = '0;
    data_in_valid = 1'b0;
    #1 RST = 1'b1;
    repeat (10) @(posedge CLK);
    #10 RST = 1'b0;
    run_vector("single_element", random_modulus(), N_SINGLE, MODE_RANDOM);
    run_vector("full_rate", random_modulus(), N_FULL, MODE_RANDOM);
    run_vector("gapped_input", random_modulus(), N_GAPPED, MODE_GAPPED);
    run_vector("modulus_three", 32'd3, N_EDGE, MODE_EDGE);
    run_vector("modulus_max", 32'hffff_ffff, N_EDGE, MODE_EDGE);
    start_and_reset();
    $display("Tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/vecmul_assert.sv */
// Protocol assertions for the vector multiplier
// Bound into vecmul_top, covering reset, ready framing and the input handshake

`timescale 1ns/100ps
`default_nettype none

module vecmul_assert #(
  parameter int LANES = 4
) (
  input logic                    CLK,
  input logic                    RST,
  input logic                    start,
  input logic                    data_in_ready,
  input logic                    data_out_valid,
  input logic                    ready,
  input vecmul_pkg::disp_state_t disp_state,
  input logic [LANES-1:0]        job_valid,
  input logic [LANES-1:0]        lane_valid,
  input logic [LANES-1:0]        lane_taken
);

  ////////////////////////////////////////
  // Reset and framing
  ////////////////////////////////////////

  // All strobes quiet while in reset
  a_reset_quiet: assert property (@(posedge CLK)
    RST |-> !data_in_ready && !data_out_valid && !ready && job_valid == '0
            && lane_valid == '0 && lane_taken == '0)
    else $error("Control outputs active during reset");

  // End-of-run pulse rides on a product
  a_ready_framed: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_valid)
    else $error("ready pulsed without data_out_valid");

  // Input handshake opens only inside a run or right after a start
  a_ready_in_run: assert property (@(posedge CLK) disable iff (RST)
    $rose(data_in_ready) |-> $past(disp_state) == vecmul_pkg::DISP_FEED || $past(start))
    else $error("data_in_ready rose while the dispatcher was idle");

endmodule

bind vecmul_top vecmul_assert #(
  .LANES(LANES)
) u_assert (
  .CLK           (CLK),
  .RST           (RST),
  .start         (start),
  .data_in_ready (data_in_ready),
  .data_out_valid(data_out_valid),
  .ready         (ready),
  .disp_state    (u_dispatch.state),
  .job_valid     (job_valid),
  .lane_valid    (lane_valid),
  .lane_taken    (lane_taken)
);

`default_nettype wire

/* src/vecmul_top.sv */
// Top level of the element-wise modular vector multiplier
// Dispatcher, generated multiplier lanes and collector

`timescale 1ns/100ps
`default_nettype none

module vecmul_top #(
  parameter int LANES = 4
) (
  input  logic               CLK,
  input  logic               RST,
  // Run control
  input  logic               start,
  input  vecmul_pkg::count_t size,
  input  vecmul_pkg::word_t  modulo,
  // Operand stream
  input  vecmul_pkg::word_t  data_a,
  input  vecmul_pkg::word_t  data_b,
  input  logic               data_in_valid,
  output logic               data_in_ready,
  // Product stream
  output vecmul_pkg::word_t  data_out,
  output logic               data_out_valid,
  output logic               ready
);

  ////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////

  // Shared job bus, one-hot strobe
  vecmul_pkg::mul_job_t job;
  logic [LANES-1:0]     job_valid;
  logic [LANES-1:0]     lane_idle;

  // Lane results towards the collector
  vecmul_pkg::word_t    lane_result [LANES];
  logic [LANES-1:0]     lane_last;
  logic [LANES-1:0]     lane_valid;
  logic [LANES-1:0]     lane_taken;

  vecmul_dispatch #(
    .LANES(LANES)
  ) u_dispatch (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size         (size),
    .modulo       (modulo),
    .data_a       (data_a),
    .data_b       (data_b),
    .data_in_valid(data_in_valid),
    .data_in_ready(data_in_ready),
    .lane_idle    (lane_idle),
    .job          (job),
    .job_valid    (job_valid)
  );

  // One multiplier per lane
  for (genvar i = 0; i < LANES; i++) begin : gen_lane
    modmul_lane u_lane (
      .CLK         (CLK),
      .RST         (RST),
      .job         (job),
      .job_valid   (job_valid[i]),
      .idle        (lane_idle[i]),
      .result      (lane_result[i]),
      .result_last (lane_last[i]),
      .result_valid(lane_valid[i]),
      .result_taken(lane_taken[i])
    );
  end

  vecmul_collect #(
    .LANES(LANES)
  ) u_collect (
    .CLK           (CLK),
    .RST           (RST),
    .result        (lane_result),
    .result_last   (lane_last),
    .result_valid  (lane_valid),
    .result_taken  (lane_taken),
    .data_out      (data_out),
    .data_out_valid(data_out_valid),
    .ready         (ready)
  );

endmodule

`default_nettype wire

/* src/vecmul_collect.sv */
// In-order collection of lane results
// Registered output strobe and end-of-run pulse

`timescale 1ns/100ps
`default_nettype none

module vecmul_collect #(
  parameter int LANES = 4
) (
  input  logic              CLK,
  input  logic              RST,
  input  vecmul_pkg::word_t result [LANES],
  input  logic [LANES-1:0]  result_last,
  input  logic [LANES-1:0]  result_valid,
  output logic [LANES-1:0]  result_taken,
  output vecmul_pkg::word_t data_out,
  output logic              data_out_valid,
  output logic              ready
);

  // Same pointer width as the dispatcher
  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [PTR_W-1:0] ptr;
  logic             take;

  ////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////

  // Only the lane at the pointer is looked at
  assign take = result_valid[ptr];

  // Acknowledge in the capture cycle
  always_comb begin
    result_taken = take ? (LANES'(1) << ptr) : '0;
  end

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ptr            <= '0;
      data_out_valid <= 1'b0;
      ready          <= 1'b0;
    end else begin
      // Strobes are single cycle
      data_out_valid <= take;
      // Last flag rides with the job, no element count here
      ready          <= take && result_last[ptr];
      if (take) begin
        ptr <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
      end
    end
  end

  // Product word
  always_ff @(posedge CLK) begin
    if (take) begin
      data_out <= result[ptr];
    end
  end

endmodule

`default_nettype wire

/* src/vecmul_dispatch.sv */
// Run control and input handshake of the vector multiplier
// Round-robin issue of operand pairs to the lanes

`timescale 1ns/100ps
`default_nettype none

module vecmul_dispatch #(
  parameter int LANES = 4
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  vecmul_pkg::count_t   size,
  input  vecmul_pkg::word_t    modulo,
  input  vecmul_pkg::word_t    data_a,
  input  vecmul_pkg::word_t    data_b,
  input  logic                 data_in_valid,
  output logic                 data_in_ready,
  input  logic [LANES-1:0]     lane_idle,
  output vecmul_pkg::mul_job_t job,
  output logic [LANES-1:0]     job_valid
);

  // At least one pointer bit, even for a single lane
  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  vecmul_pkg::disp_state_t state;

  // Run parameters latched at start
  vecmul_pkg::count_t size_q;
  vecmul_pkg::word_t  modulo_q;

  // Pairs accepted so far in this run
  vecmul_pkg::count_t in_cnt;
  logic [PTR_W-1:0]   ptr;

  logic accept;
  logic is_last;

  ////////////////////////////////////////
  // Handshake and job build
  ////////////////////////////////////////

  // Only the lane at the pointer may take the next pair
  assign data_in_ready = (state == vecmul_pkg::DISP_FEED) && lane_idle[ptr];
  assign accept        = data_in_valid && data_in_ready;
  assign is_last       = (in_cnt == size_q - vecmul_pkg::count_t'(1));

  always_comb begin
    job.a      = data_a;
    job.b      = data_b;
    job.modulo = modulo_q;
    job.last   = is_last;
    // One-hot strobe for the selected lane
    job_valid  = accept ? (LANES'(1) << ptr) : '0;
  end

  ////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= vecmul_pkg::DISP_IDLE;
      in_cnt <= '0;
      ptr    <= '0;
    end else begin
      unique case (state)
        vecmul_pkg::DISP_IDLE: begin
          // Zero length runs are dropped
          if (start && size != '0) begin
            state  <= vecmul_pkg::DISP_FEED;
            in_cnt <= '0;
          end
        end
        vecmul_pkg::DISP_FEED: begin
          if (accept) begin
            in_cnt <= in_cnt + 1'b1;
            // Pointer carries over between runs, collector stays aligned
            ptr    <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
            if (is_last) begin
              state <= vecmul_pkg::DISP_IDLE;
            end
          end
        end
        default: state <= vecmul_pkg::DISP_IDLE;
      endcase
    end
  end

  // Run parameters
  always_ff @(posedge CLK) begin
    if (state == vecmul_pkg::DISP_IDLE && start) begin
      size_q   <= size;
      modulo_q <= modulo;
    end
  end

endmodule

`default_nettype wire

/* src/modmul_lane.sv */
// Sequential modular multiplier lane
// Interleaved shift-and-reduce, one bit of a per cycle, MSB first

`timescale 1ns/100ps
`default_nettype none

module modmul_lane (
  input  logic                 CLK,
  input  logic                 RST,
  input  vecmul_pkg::mul_job_t job,
  input  logic                 job_valid,
  output logic                 idle,
  output vecmul_pkg::word_t    result,
  output logic                 result_last,
  output logic                 result_valid,
  input  logic                 result_taken
);

  localparam int W = vecmul_pkg::WORD_W;
  // Counts W steps plus the final store cycle
  localparam int CNT_W = $clog2(W + 1);

  vecmul_pkg::lane_state_t state;
  logic [CNT_W-1:0]        step_cnt;

  // Operands held for the whole job
  vecmul_pkg::word_t a_sh;
  vecmul_pkg::word_t b_q;
  vecmul_pkg::word_t mod_q;
  vecmul_pkg::word_t acc;
  logic              last_q;

  // One extra bit so that 2*acc and acc+b never overflow
  logic [W:0] mod_ext;
  logic [W:0] dbl;
  logic [W:0] dbl_red;
  logic [W:0] sum;
  logic [W:0] sum_red;

  ////////////////////////////////////////
  // One reduction step
  ////////////////////////////////////////

  always_comb begin
    mod_ext = {1'b0, mod_q};
    // acc < m, so 2*acc < 2m and one subtract is enough
    dbl     = {acc, 1'b0};
    dbl_red = (dbl >= mod_ext) ? dbl - mod_ext : dbl;
    // Add b when the current bit of a is set
    sum     = dbl_red + (a_sh[W-1] ? {1'b0, b_q} : '0);
    sum_red = (sum >= mod_ext) ? sum - mod_ext : sum;
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= vecmul_pkg::LANE_IDLE;
      step_cnt <= '0;
    end else begin
      unique case (state)
        vecmul_pkg::LANE_IDLE: begin
          if (job_valid) begin
            state    <= vecmul_pkg::LANE_RUN;
            step_cnt <= '0;
          end
        end
        vecmul_pkg::LANE_RUN: begin
          // Last RUN cycle stores the remainder
          if (step_cnt == CNT_W'(W)) begin
            state <= vecmul_pkg::LANE_DONE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        vecmul_pkg::LANE_DONE: begin
          // Hold until the collector takes it
          if (result_taken) begin
            state <= vecmul_pkg::LANE_IDLE;
          end
        end
        default: state <= vecmul_pkg::LANE_IDLE;
      endcase
    end
  end

  // Datapath, no reset
  always_ff @(posedge CLK) begin
    if (state == vecmul_pkg::LANE_IDLE && job_valid) begin
      a_sh   <= job.a;
      b_q    <= job.b;
      mod_q  <= job.modulo;
      last_q <= job.last;
      acc    <= '0;
    end else if (state == vecmul_pkg::LANE_RUN) begin
      if (step_cnt == CNT_W'(W)) begin
        result <= acc;
      end else begin
        acc  <= sum_red[W-1:0];
        a_sh <= {a_sh[W-2:0], 1'b0};
      end
    end
  end

  assign idle         = (state == vecmul_pkg::LANE_IDLE);
  assign result_valid = (state == vecmul_pkg::LANE_DONE);
  assign result_last  = last_q;

endmodule

`default_nettype wire

/* src/vecmul_pkg.sv */
// Shared word and count types for the vector modular multiplier
// Job struct passed from dispatcher to lanes
// State encodings of the lane and dispatcher FSMs

`default_nettype none

package vecmul_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Operand, modulus and product width
  localparam int WORD_W = 32;

  // Width of vector length and element counts
  localparam int COUNT_W = 16;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [COUNT_W-1:0] count_t;

  // One element of work for a lane
  typedef struct packed {
    word_t a;
    word_t b;
    word_t modulo;
    // Final element of the run
    logic  last;
  } mul_job_t;

  ////////////////////////////////////////
  // State machines
  ////////////////////////////////////////

  // Lane: waiting, iterating, holding a result
  typedef enum logic [1:0] {
    LANE_IDLE = 2'd0,
    LANE_RUN  = 2'd1,
    LANE_DONE = 2'd2
  } lane_state_t;

  // Dispatcher: no run, or feeding pairs of a run
  typedef enum logic {
    DISP_IDLE = 1'b0,
    DISP_FEED = 1'b1
  } disp_state_t;

endpackage

`default_nettype wire
